// ==== verilog/invaders_pkg.sv ====
// shared playfield types, limits and the shot state encoding
// imported by every game-logic module that handles positions or score

package invaders_pkg;

   // playfield is 20 columns by 16 rows, row 0 at the top
   typedef logic [4:0] column_t;   // 0 to 19
   typedef logic [3:0] row_t;      // 0 is the top row
   typedef logic [7:0] score_t;    // kill count, wraps at 256

   // player shot, only one on screen at a time
   typedef enum logic {
      SHOT_IDLE,     // nothing on screen
      SHOT_FLYING    // moving up one row per tick
   } shot_state_e;

   // ship column bounds
   localparam column_t LEFT_LIMIT     = 5'd0;
   localparam column_t RIGHT_LIMIT    = 5'd19;
   localparam column_t RESET_POSITION = 5'd5;   // where the ship sits after reset

   // new shot appears just above the ship row
   localparam row_t SHOT_START_ROW = 4'd14;

endpackage

// ==== verilog/button_debouncer.sv ====
// debounces one raw push button into a clean level
// output follows the input once it has been stable for DEBOUNCE_CYCLES clocks
`timescale 1ns/100ps

module button_debouncer #(
   parameter int DEBOUNCE_CYCLES = 250000
) (
   input  logic i_clk_25MHz,
   input  logic i_reset,       // sync, active high
   input  logic i_button,      // raw, asynchronous to the clock
   output logic o_level        // debounced level
);

   localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

   logic             sync_q1;  // first synchronizer stage
   logic             sync_q2;  // second stage, safe to use
   logic [CNT_W-1:0] stable_cnt;

   // two-flop synchronizer
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         sync_q1 <= 1'b0;
         sync_q2 <= 1'b0;
      end else begin
         sync_q1 <= i_button;
         sync_q2 <= sync_q1;
      end
   end

   // count how long the sample has disagreed with the output
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         stable_cnt <= '0;
         o_level    <= 1'b0;
      end else if (sync_q2 == o_level) begin
         stable_cnt <= '0;                          // bounce back, start over
      end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
         stable_cnt <= '0;
         o_level    <= sync_q2;                     // held long enough, accept it
      end else begin
         stable_cnt <= stable_cnt + 1'b1;
      end
   end

endmodule

// ==== verilog/ship_control.sv ====
// frame tick generator and player ship position
// ship steps one column per tick, left wins over right, clamps at the edges
`timescale 1ns/100ps

module ship_control import invaders_pkg::*; #(
   parameter int FRAME_DIV = 416666
) (
   input  logic    i_clk_25MHz,
   input  logic    i_reset,       // sync, active high
   input  logic    i_left,        // debounced left button
   input  logic    i_right,       // debounced right button
   output logic    o_frame_tick,  // one-cycle pulse every FRAME_DIV clocks
   output column_t o_ship_x       // current ship column
);

   localparam int DIV_W = $clog2(FRAME_DIV);

   logic [DIV_W-1:0] div_cnt;   // frame divider

   // frame divider, tick registered so it is glitch free
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         div_cnt      <= '0;
         o_frame_tick <= 1'b0;
      end else if (div_cnt == DIV_W'(FRAME_DIV - 1)) begin
         div_cnt      <= '0;
         o_frame_tick <= 1'b1;      // wrap, fire the tick
      end else begin
         div_cnt      <= div_cnt + 1'b1;
         o_frame_tick <= 1'b0;
      end
   end

   // ship position, only moves on a tick
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         o_ship_x <= RESET_POSITION;
      end else if (o_frame_tick) begin
         if (i_left) begin
            if (o_ship_x != LEFT_LIMIT)
               o_ship_x <= o_ship_x - 1'b1;   // step left
            // else parked on the left edge
         end else if (i_right) begin
            if (o_ship_x != RIGHT_LIMIT)
               o_ship_x <= o_ship_x + 1'b1;   // step right
            // else parked on the right edge
         end
      end
   end

endmodule

// ==== verilog/shot_unit.sv ====
// single player shot: launch from the ship, climb one row per tick, retire
// fire is edge triggered and waits as a pending request for the next tick
`timescale 1ns/100ps

module shot_unit import invaders_pkg::*; (
   input  logic    i_clk_25MHz,
   input  logic    i_reset,        // sync, active high
   input  logic    i_fire,         // debounced fire level
   input  logic    i_frame_tick,   // advance pulse
   input  column_t i_ship_x,       // launch column
   input  logic    i_shot_clear,   // shot hit something, remove it
   output logic    o_shot_active,
   output column_t o_shot_x,
   output row_t    o_shot_y
);

   shot_state_e shot_state;
   logic        fire_q;       // previous fire level
   logic        fire_edge;    // rising edge of fire
   logic        fire_pending; // request waiting for a tick

   assign fire_edge     = i_fire & ~fire_q;
   assign o_shot_active = (shot_state == SHOT_FLYING);

   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         fire_q <= 1'b0;
      end else begin
         fire_q <= i_fire;
      end
   end

   // state, position and pending request
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         shot_state   <= SHOT_IDLE;
         fire_pending <= 1'b0;
         o_shot_x     <= '0;
         o_shot_y     <= '0;
      end else begin
         if (i_frame_tick)
            fire_pending <= fire_edge;      // request consumed or dropped, new edge kept
         else if (fire_edge)
            fire_pending <= 1'b1;

         if (i_shot_clear) begin
            shot_state <= SHOT_IDLE;        // clear beats the tick
         end else if (i_frame_tick) begin
            case (shot_state)
               SHOT_IDLE: begin
                  if (fire_pending) begin
                     shot_state <= SHOT_FLYING;
                     o_shot_x   <= i_ship_x;         // column fixed for the flight
                     o_shot_y   <= SHOT_START_ROW;
                  end
               end
               SHOT_FLYING: begin
                  if (o_shot_y == '0)
                     shot_state <= SHOT_IDLE;        // left the top of the field
                  else
                     o_shot_y <= o_shot_y - 1'b1;    // climb one row
               end
               default: shot_state <= SHOT_IDLE;
            endcase
         end
      end
   end

endmodule

// ==== verilog/alien_slot.sv ====
// one alien at a fixed playfield cell
// flags a hit when the flying shot lands on its cell, dies, comes back on rearm
`timescale 1ns/100ps

module alien_slot import invaders_pkg::*; #(
   parameter int ALIEN_COL = 2,
   parameter int ALIEN_ROW = 3
) (
   input  logic    i_clk_25MHz,
   input  logic    i_reset,         // sync, active high
   input  logic    i_shot_active,
   input  column_t i_shot_x,
   input  row_t    i_shot_y,
   input  logic    i_rearm,         // new wave, come back to life
   output logic    o_hit,           // one-cycle hit pulse
   output logic    o_alive
);

   logic on_cell;   // shot sits exactly on this alien

   assign on_cell = (i_shot_x == column_t'(ALIEN_COL)) &&
                    (i_shot_y == row_t'(ALIEN_ROW));

   // only a live alien can be hit, alive drops next cycle so it pulses once
   assign o_hit = o_alive & i_shot_active & on_cell;

   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         o_alive <= 1'b1;          // every wave starts full
      end else if (i_rearm) begin
         o_alive <= 1'b1;
      end else if (o_hit) begin
         o_alive <= 1'b0;          // killed
      end
   end

endmodule

// ==== verilog/score_keeper.sv ====
// gathers alien hit pulses, counts the score and manages waves
// clears the shot after a hit and rearms the row once the last alien dies
`timescale 1ns/100ps

module score_keeper import invaders_pkg::*; #(
   parameter int NUM_ALIENS = 5
) (
   input  logic                  i_clk_25MHz,
   input  logic                  i_reset,       // sync, active high
   input  logic [NUM_ALIENS-1:0] i_hit,         // at most one bit set per cycle
   input  logic [NUM_ALIENS-1:0] i_alive,
   output logic                  o_shot_clear,  // remove the shot
   output logic                  o_rearm,       // start a new wave
   output score_t                o_score
);

   logic                  any_hit;      // some alien was hit this cycle
   logic [NUM_ALIENS-1:0] survivors;    // alive minus the one just hit
   logic                  wave_done;

   always_comb begin
      any_hit   = |i_hit;
      survivors = i_alive & ~i_hit;
      wave_done = any_hit && (survivors == '0);   // the last one went down
   end

   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         o_shot_clear <= 1'b0;
         o_rearm      <= 1'b0;
         o_score      <= '0;
      end else begin
         o_shot_clear <= any_hit;    // one-cycle pulse back to the shot
         o_rearm      <= wave_done;
         if (any_hit)
            o_score <= o_score + 1'b1;   // wraps past 255
      end
   end

endmodule

// ==== verilog/invaders_core.sv ====
// game-logic core of the shooter, no video or sound
// buttons in, ship, shot, alien row and score out
`timescale 1ns/100ps

module invaders_core import invaders_pkg::*; #(
   parameter int FRAME_DIV       = 416666,  // clocks per frame tick
   parameter int DEBOUNCE_CYCLES = 250000,  // stable samples per button
   parameter int NUM_ALIENS      = 5,
   parameter int ALIEN_ROW       = 3,
   parameter int ALIEN_SPACING   = 4,       // columns between slots
   parameter int ALIEN_OFFSET    = 2        // column of slot 0
) (
   input  logic                  i_clk_25MHz,
   input  logic                  i_reset,        // sync, active high
   input  logic                  i_btn_left,
   input  logic                  i_btn_right,
   input  logic                  i_btn_fire,
   output logic                  o_frame_tick,
   output column_t               o_ship_x,
   output logic                  o_shot_active,
   output column_t               o_shot_x,
   output row_t                  o_shot_y,
   output logic [NUM_ALIENS-1:0] o_alive,
   output score_t                o_score
);

   logic                  left_level;
   logic                  right_level;
   logic                  fire_level;
   logic                  shot_clear;   // score keeper -> shot
   logic                  rearm;        // score keeper -> all slots
   logic [NUM_ALIENS-1:0] hit_vec;

   // buttons
   button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_left (
      .i_clk_25MHz(i_clk_25MHz), .i_reset(i_reset),
      .i_button(i_btn_left), .o_level(left_level));
   button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_right (
      .i_clk_25MHz(i_clk_25MHz), .i_reset(i_reset),
      .i_button(i_btn_right), .o_level(right_level));
   button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_fire (
      .i_clk_25MHz(i_clk_25MHz), .i_reset(i_reset),
      .i_button(i_btn_fire), .o_level(fire_level));

   ship_control #(.FRAME_DIV(FRAME_DIV)) i_ship_control (
      .i_clk_25MHz(i_clk_25MHz), .i_reset(i_reset),
      .i_left(left_level), .i_right(right_level),
      .o_frame_tick(o_frame_tick), .o_ship_x(o_ship_x));

   shot_unit i_shot_unit (
      .i_clk_25MHz(i_clk_25MHz), .i_reset(i_reset),
      .i_fire(fire_level), .i_frame_tick(o_frame_tick),
      .i_ship_x(o_ship_x), .i_shot_clear(shot_clear),
      .o_shot_active(o_shot_active), .o_shot_x(o_shot_x), .o_shot_y(o_shot_y));

   // alien line, slot k at column k*spacing + offset
   for (genvar k = 0; k < NUM_ALIENS; k++) begin : g_alien
      alien_slot #(
         .ALIEN_COL(k * ALIEN_SPACING + ALIEN_OFFSET),
         .ALIEN_ROW(ALIEN_ROW)
      ) i_alien_slot (
         .i_clk_25MHz(i_clk_25MHz), .i_reset(i_reset),
         .i_shot_active(o_shot_active), .i_shot_x(o_shot_x), .i_shot_y(o_shot_y),
         .i_rearm(rearm), .o_hit(hit_vec[k]), .o_alive(o_alive[k]));
   end

   score_keeper #(.NUM_ALIENS(NUM_ALIENS)) i_score_keeper (
      .i_clk_25MHz(i_clk_25MHz), .i_reset(i_reset),
      .i_hit(hit_vec), .i_alive(o_alive),
      .o_shot_clear(shot_clear), .o_rearm(rearm), .o_score(o_score));

endmodule

// ==== verification/invaders_asserts.sv ====
// safety properties of the game core, bound into every invaders_core instance
`timescale 1ns/100ps

module invaders_asserts import invaders_pkg::*; #(
   parameter int NUM_ALIENS = 5
) (
   input logic                  i_clk_25MHz,
   input logic                  i_reset,
   input column_t               i_ship_x,
   input row_t                  i_shot_y,
   input logic                  i_rearm,     // internal wave restart pulse
   input logic [NUM_ALIENS-1:0] i_alive,
   input score_t                i_score
);

   int fail_count = 0;   // running tally of assertion failures

   // left edge is column 0, unsigned, so only the right bound can break
   a_ship_in_field: assert property (@(posedge i_clk_25MHz) disable iff (i_reset)
      i_ship_x <= RIGHT_LIMIT)
   else begin
      $error("ship column %0d outside the playfield", i_ship_x);
      fail_count++;
   end

   a_shot_row: assert property (@(posedge i_clk_25MHz) disable iff (i_reset)
      i_shot_y <= SHOT_START_ROW)   // shot only ever climbs
   else begin
      $error("shot row %0d below the launch row", i_shot_y);
      fail_count++;
   end

   // one kill per cycle at most, wrap included
   a_score_step: assert property (@(posedge i_clk_25MHz) disable iff (i_reset)
      (i_score == $past(i_score)) || (i_score == score_t'($past(i_score) + 1'b1)))
   else begin
      $error("score jumped to %0d", i_score);
      fail_count++;
   end

   a_rearm_fills: assert property (@(posedge i_clk_25MHz) disable iff (i_reset)
      i_rearm |=> (&i_alive))
   else begin
      $error("alive vector %b not full after rearm", i_alive);
      fail_count++;
   end

endmodule

bind invaders_core invaders_asserts #(.NUM_ALIENS(NUM_ALIENS)) i_invaders_asserts (
   .i_clk_25MHz(i_clk_25MHz), .i_reset(i_reset), .i_ship_x(o_ship_x),
   .i_shot_y(o_shot_y), .i_rearm(rearm), .i_alive(o_alive), .i_score(o_score));

// ==== verification/invaders_tb.sv ====
// table driven testbench for invaders_core, short frame and debounce counts
// each step holds the buttons for some ticks, then checks ship, shot, aliens, score
`timescale 1ns/100ps

module invaders_tb import invaders_pkg::*;;

   localparam int FRAME_DIV  = 16;
   localparam int NUM_ALIENS = 5;
   localparam int NUM_STEPS  = 27;

   typedef struct packed {
      logic                  rst;      // mid-run reset instead of buttons
      logic                  left;
      logic                  right;
      logic                  fire;
      logic [7:0]            ticks;    // ticks the buttons are held
      column_t               ship;     // expected ship column (and shot column when flying)
      logic                  active;
      row_t                  row;      // expected shot row, checked only when flying
      logic [NUM_ALIENS-1:0] alive;
      score_t                score;
   } step_t;

   // rst left right fire | ticks | ship active row alive score
   // the tick at which a step starts still sees the previous step's buttons
   localparam step_t STEPS [NUM_STEPS] = '{
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd0,  5'd5,  1'b0, 4'd0,  5'b11111, 8'd0},  // after reset
      '{1'b0, 1'b1, 1'b0, 1'b0, 8'd7,  5'd0,  1'b0, 4'd0,  5'b11111, 8'd0},  // clamps left
      '{1'b0, 1'b0, 1'b1, 1'b0, 8'd25, 5'd19, 1'b0, 4'd0,  5'b11111, 8'd0},  // clamps right
      '{1'b0, 1'b1, 1'b1, 1'b0, 8'd3,  5'd16, 1'b0, 4'd0,  5'b11111, 8'd0},  // left wins
      '{1'b0, 1'b1, 1'b0, 1'b0, 8'd16, 5'd0,  1'b0, 4'd0,  5'b11111, 8'd0},
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd1,  5'd0,  1'b1, 4'd14, 5'b11111, 8'd0},  // launch at col 0
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd14, 5'd0,  1'b0, 4'd0,  5'b11111, 8'd0},  // off the top, miss
      '{1'b0, 1'b0, 1'b1, 1'b0, 8'd1,  5'd1,  1'b0, 4'd0,  5'b11111, 8'd0},
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd1,  5'd2,  1'b1, 4'd14, 5'b11111, 8'd0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd2,  5'd2,  1'b1, 4'd11, 5'b11111, 8'd0},
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd2,  5'd2,  1'b1, 4'd8,  5'b11111, 8'd0},  // second fire lost
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd5,  5'd2,  1'b0, 4'd0,  5'b11110, 8'd1},  // alien 0 down
      '{1'b0, 1'b0, 1'b1, 1'b0, 8'd3,  5'd5,  1'b0, 4'd0,  5'b11110, 8'd1},
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd1,  5'd6,  1'b1, 4'd14, 5'b11110, 8'd1},
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd11, 5'd6,  1'b0, 4'd0,  5'b11100, 8'd2},
      '{1'b0, 1'b0, 1'b1, 1'b0, 8'd3,  5'd9,  1'b0, 4'd0,  5'b11100, 8'd2},
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd1,  5'd10, 1'b1, 4'd14, 5'b11100, 8'd2},
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd11, 5'd10, 1'b0, 4'd0,  5'b11000, 8'd3},
      '{1'b0, 1'b0, 1'b1, 1'b0, 8'd3,  5'd13, 1'b0, 4'd0,  5'b11000, 8'd3},
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd1,  5'd14, 1'b1, 4'd14, 5'b11000, 8'd3},
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd11, 5'd14, 1'b0, 4'd0,  5'b10000, 8'd4},
      '{1'b0, 1'b0, 1'b1, 1'b0, 8'd3,  5'd17, 1'b0, 4'd0,  5'b10000, 8'd4},
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd1,  5'd18, 1'b1, 4'd14, 5'b10000, 8'd4},
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd11, 5'd18, 1'b0, 4'd0,  5'b11111, 8'd5},  // wave rearmed
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd1,  5'd18, 1'b1, 4'd14, 5'b11111, 8'd5},
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd11, 5'd18, 1'b0, 4'd0,  5'b01111, 8'd6},
      '{1'b1, 1'b0, 1'b0, 1'b0, 8'd0,  5'd5,  1'b0, 4'd0,  5'b11111, 8'd0}   // mid-run reset
   };

   // every step costs its own ticks plus the start tick
   function automatic int run_length_cycles();
      int total = 0;
      for (int i = 0; i < NUM_STEPS; i++)
         total += int'(STEPS[i].ticks) + 1;
      return total * FRAME_DIV + 200;
   endfunction

   localparam int CYCLE_LIMIT = run_length_cycles();

   logic                  i_clk_25MHz;
   logic                  i_reset;
   logic                  i_btn_left;
   logic                  i_btn_right;
   logic                  i_btn_fire;
   logic                  o_frame_tick;
   column_t               o_ship_x;
   logic                  o_shot_active;
   column_t               o_shot_x;
   row_t                  o_shot_y;
   logic [NUM_ALIENS-1:0] o_alive;
   score_t                o_score;
   int                    error_count = 0;
   int                    cycle_count = 0;
   int                    frame_phase = 0;   // cycles since reset release

   invaders_core #(
      .FRAME_DIV(FRAME_DIV), .DEBOUNCE_CYCLES(4), .NUM_ALIENS(NUM_ALIENS)
   ) i_invaders_core (
      .i_clk_25MHz(i_clk_25MHz), .i_reset(i_reset), .i_btn_left(i_btn_left),
      .i_btn_right(i_btn_right), .i_btn_fire(i_btn_fire), .o_frame_tick(o_frame_tick),
      .o_ship_x(o_ship_x), .o_shot_active(o_shot_active), .o_shot_x(o_shot_x),
      .o_shot_y(o_shot_y), .o_alive(o_alive), .o_score(o_score));

   initial begin
      i_clk_25MHz = 1'b0;
      forever #20 i_clk_25MHz = ~i_clk_25MHz;   // 25 MHz
   end

   task automatic check_column(input column_t got, input column_t exp, input string name);
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_row(input row_t got, input row_t exp, input string name);
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_score(input score_t got, input score_t exp, input string name);
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_alive(input logic [NUM_ALIENS-1:0] got,
                              input logic [NUM_ALIENS-1:0] exp, input string name);
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string name);
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   // returns on the rising edge where the DUT acts on a tick
   task automatic wait_tick();
      @(negedge i_clk_25MHz);
      while (o_frame_tick !== 1'b1)
         @(negedge i_clk_25MHz);
      @(posedge i_clk_25MHz);
   endtask

   // tick expected every FRAME_DIV cycles after reset release
   always @(negedge i_clk_25MHz) begin
      if (i_reset) begin
         frame_phase <= 0;
      end else begin
         check_flag(o_frame_tick, (frame_phase != 0) && (frame_phase % FRAME_DIV == 0),
                    "o_frame_tick");
         frame_phase <= frame_phase + 1;
      end
   end

   always @(posedge i_clk_25MHz) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
         $display("Testbench failed");
         $finish;
      end
   end

   initial begin
      int total_errors;
      i_reset     = 1'b1;
      i_btn_left  = 1'b0;
      i_btn_right = 1'b0;
      i_btn_fire  = 1'b0;
      void'($urandom(31340));
      repeat (5) @(posedge i_clk_25MHz);
      i_reset <= 1'b0;

      for (int s = 0; s < NUM_STEPS; s++) begin
         if (STEPS[s].rst) begin
            @(posedge i_clk_25MHz);
            i_reset     <= 1'b1;
            i_btn_left  <= 1'b0;
            i_btn_right <= 1'b0;
            i_btn_fire  <= 1'b0;
            repeat (5) @(posedge i_clk_25MHz);
            i_reset <= 1'b0;
         end else begin
            wait_tick();                     // drive right after a tick
            i_btn_left  <= STEPS[s].left;
            i_btn_right <= STEPS[s].right;
            i_btn_fire  <= STEPS[s].fire;
            repeat (STEPS[s].ticks) wait_tick();
         end
         repeat (4) @(posedge i_clk_25MHz);  // hit and rearm settle in 3
         @(negedge i_clk_25MHz);
         check_column(o_ship_x, STEPS[s].ship, "o_ship_x");
         check_flag(o_shot_active, STEPS[s].active, "o_shot_active");
         if (STEPS[s].active) begin
            check_column(o_shot_x, STEPS[s].ship, "o_shot_x");
            check_row(o_shot_y, STEPS[s].row, "o_shot_y");
         end
         check_alive(o_alive, STEPS[s].alive, "o_alive");
         check_score(o_score, STEPS[s].score, "o_score");
         repeat ($urandom_range(3, 0)) @(posedge i_clk_25MHz);   // idle gap
      end

      total_errors = error_count + i_invaders_core.i_invaders_asserts.fail_count;
      $display("errors: %0d (value checks %0d, assertions %0d)", total_errors,
               error_count, i_invaders_core.i_invaders_asserts.fail_count);
      if (total_errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== filelist.f ====
verilog/invaders_pkg.sv
verilog/button_debouncer.sv
verilog/ship_control.sv
verilog/shot_unit.sv
verilog/alien_slot.sv
verilog/score_keeper.sv
verilog/invaders_core.sv
verification/invaders_asserts.sv
verification/invaders_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the invaders core testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module invaders_tb -f filelist.f -Mdir obj_dir -o invaders_sim

./obj_dir/invaders_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
   echo "simulation PASS"
else
   echo "simulation FAIL"
   exit 1
fi
